//--- design/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// core-side widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// mtime halves, served locally and never sent to axi
`define BUS_RTC_ADDR    32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

`endif

//--- design/axi_pkg.sv
`include "bus_config.svh"

package axi_pkg;

  // single-beat transfer sizes
  typedef enum logic [2:0] {
    AXI_SIZE_1 = 3'b000,
    AXI_SIZE_2 = 3'b001,
    AXI_SIZE_4 = 3'b010
  } axi_size_t;

  // only okay is expected back
  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_EXOKAY = 2'b01,
    AXI_RESP_SLVERR = 2'b10,
    AXI_RESP_DECERR = 2'b11
  } axi_resp_t;

  // 64-bit data beat
  // lanes for read selection and replicated write data,
  // bytes for strobed writes into memory
  typedef union packed {
    logic [1:0][`BUS_DATA_W-1:0] lane;
    logic [7:0][7:0]             bytes;
  } axi_beat_u;

endpackage

//--- design/core_bus_pkg.sv
package core_bus_pkg;

  // arbiter states
  typedef enum logic [2:0] {
    IF_A   = 3'b000,
    IF_D   = 3'b001,
    LS_A   = 3'b010,
    LS_D_R = 3'b011,
    LS_D_W = 3'b100
  } arb_state_t;

  // load/store access width, same coding as the axi size field
  typedef enum logic [1:0] {
    MW_BYTE = 2'b00,
    MW_HALF = 2'b01,
    MW_WORD = 2'b10
  } mem_width_t;

endpackage

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_arbiter
  import core_bus_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // ifu fetch
  input  logic [`BUS_ADDR_W-1:0] ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic [`BUS_DATA_W-1:0] ifu_rdata_o,
  output logic                   ifu_rvalid_o,

  // lsu load
  input  logic [`BUS_ADDR_W-1:0] lsu_araddr_i,
  input  logic [7:0]             lsu_rstrb_i,
  input  logic                   lsu_arvalid_i,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_rvalid_o,

  // lsu store
  input  logic [`BUS_ADDR_W-1:0] lsu_awaddr_i,
  input  logic                   lsu_wvalid_i,
  output logic                   lsu_wready_o,

  // axi handshakes
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  logic                   m_rvalid_i,
  output logic                   m_awvalid_o,
  input  logic                   m_awready_i,
  output logic                   m_wvalid_o,
  input  logic                   m_wready_i,
  input  logic                   m_bvalid_i,

  // to and from the lane aligner
  output logic [`BUS_ADDR_W-1:0] sel_araddr_o,
  output logic [7:0]             sel_rstrb_o,
  output logic                   ifetch_o,
  input  logic [`BUS_DATA_W-1:0] lane_rdata_i,

  // timer
  output logic                   clint_arvalid_o,
  input  logic [`BUS_DATA_W-1:0] clint_rdata_i,
  input  logic                   clint_rvalid_i
);

  arb_state_t state;
  arb_state_t state_nxt;

  logic aw_done;
  logic w_done;
  logic ar_hold;
  logic lsu_pend;
  logic clint_hit;
  logic store_req;
  logic load_req;

  assign lsu_pend  = lsu_arvalid_i | lsu_wvalid_i;
  assign clint_hit = (lsu_araddr_i == `BUS_RTC_ADDR) | (lsu_araddr_i == `BUS_RTC_ADDR_UP);

  // store wins if both lsu requests are up
  assign store_req = (state == LS_A) & lsu_wvalid_i;
  assign load_req  = (state == LS_A) & lsu_arvalid_i & !lsu_wvalid_i;

  assign ifetch_o     = (state == IF_A) | (state == IF_D);
  assign sel_araddr_o = ifetch_o ? ifu_araddr_i : lsu_araddr_i;
  assign sel_rstrb_o  = ifetch_o ? 8'h0f : lsu_rstrb_i;

  // an ar already shown to the slave is kept until accepted
  assign m_arvalid_o = ((state == IF_A) & ifu_arvalid_i & (ar_hold | !lsu_pend))
                     | (load_req & !clint_hit);
  assign m_awvalid_o = store_req & !aw_done;
  assign m_wvalid_o  = store_req & !w_done;

  assign clint_arvalid_o = load_req & clint_hit;

  assign ifu_rdata_o  = lane_rdata_i;
  assign ifu_rvalid_o = (state == IF_D) & m_rvalid_i;

  assign lsu_rdata_o  = clint_hit ? clint_rdata_i : lane_rdata_i;
  assign lsu_rvalid_o = (state == LS_D_R) & (clint_hit ? clint_rvalid_i : m_rvalid_i);
  assign lsu_wready_o = store_req & m_bvalid_i;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IF_A:
      begin
        if (lsu_pend & !ar_hold)
          state_nxt = LS_A;
        else if (m_arvalid_o & m_arready_i)
          state_nxt = IF_D;
      end
      IF_D:
      begin
        if (m_rvalid_i)
          state_nxt = lsu_pend ? LS_A : IF_A;
      end
      LS_A:
      begin
        if (store_req)
        begin
          if (m_bvalid_i)
            state_nxt = LS_D_W;
        end
        else if (clint_arvalid_o | (m_arvalid_o & m_arready_i))
          state_nxt = LS_D_R;
        else if (!lsu_arvalid_i)
          state_nxt = IF_A;
      end
      LS_D_R:
      begin
        if (lsu_rvalid_o)
          state_nxt = IF_A;
      end
      LS_D_W:
        state_nxt = IF_A;
      default:
        state_nxt = IF_A;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= IF_A;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      ar_hold <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      ar_hold <= (state == IF_A) & m_arvalid_o & !m_arready_i;
      // aw and w retire independently
      if (state == LS_A)
      begin
        if (m_awvalid_o & m_awready_i)
          aw_done <= 1'b1;
        if (m_wvalid_o & m_wready_i)
          w_done <= 1'b1;
      end
      else
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
    end
  end

endmodule

//--- design/axi_lane_align.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module axi_lane_align
  import axi_pkg::*;
  import core_bus_pkg::*;
(
  input  logic [`BUS_ADDR_W-1:0]   sel_araddr_i,
  input  logic [7:0]               sel_rstrb_i,
  input  logic                     ifetch_i,
  input  logic [`BUS_ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]   lsu_wdata_i,
  input  logic [7:0]               lsu_wstrb_i,
  input  logic [2*`BUS_DATA_W-1:0] m_rdata_i,
  output axi_size_t                m_arsize_o,
  output axi_size_t                m_awsize_o,
  output logic [2*`BUS_DATA_W-1:0] m_wdata_o,
  output logic [7:0]               m_wstrb_o,
  output logic [`BUS_DATA_W-1:0]   lane_rdata_o
);

  function automatic mem_width_t strb_width(input logic [7:0] strb);
    case (strb)
      8'h01:   return MW_BYTE;
      8'h03:   return MW_HALF;
      8'h0f:   return MW_WORD;
      default: return MW_BYTE;
    endcase
  endfunction

  function automatic axi_size_t width_size(input mem_width_t w);
    case (w)
      MW_HALF: return AXI_SIZE_2;
      MW_WORD: return AXI_SIZE_4;
      default: return AXI_SIZE_1;
    endcase
  endfunction

  axi_beat_u                wbeat;
  axi_beat_u                rbeat;
  logic [`BUS_DATA_W-1:0]   wdata_sh;
  logic [3:0]               wstrb_sh;

  // fetches are always full words
  assign m_arsize_o = ifetch_i ? AXI_SIZE_4 : width_size(strb_width(sel_rstrb_i));
  assign m_awsize_o = width_size(strb_width(lsu_wstrb_i));

  // move store data to its byte offset
  assign wdata_sh = lsu_wdata_i << {lsu_awaddr_i[1:0], 3'b000};
  assign wstrb_sh = lsu_wstrb_i[3:0] << lsu_awaddr_i[1:0];

  // same word in both halves, strobe picks the half
  assign wbeat.lane[0] = wdata_sh;
  assign wbeat.lane[1] = wdata_sh;
  assign m_wdata_o     = wbeat;
  assign m_wstrb_o     = lsu_awaddr_i[2] ? {wstrb_sh, 4'b0000} : {4'b0000, wstrb_sh};

  assign rbeat        = m_rdata_i;
  assign lane_rdata_o = rbeat.lane[sel_araddr_i[2]];

endmodule

//--- design/clint_timer.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUS_ADDR_W-1:0] araddr_i,
  input  logic                   arvalid_i,
  output logic [`BUS_DATA_W-1:0] rdata_o,
  output logic                   rvalid_o
);

  logic [63:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= 64'd0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 64'd1;
      rvalid_o <= arvalid_i;
    end
  end

  // value as of the request cycle, bit 2 picks the half
  always_ff @(posedge clk)
  begin
    if (arvalid_i)
      rdata_o <= araddr_i[2] ? mtime[63:32] : mtime[31:0];
  end

endmodule

//--- design/core_bus_top.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module core_bus_top
  import axi_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  input  logic [`BUS_ADDR_W-1:0]   ifu_araddr_i,
  input  logic                     ifu_arvalid_i,
  output logic [`BUS_DATA_W-1:0]   ifu_rdata_o,
  output logic                     ifu_rvalid_o,

  input  logic [`BUS_ADDR_W-1:0]   lsu_araddr_i,
  input  logic [7:0]               lsu_rstrb_i,
  input  logic                     lsu_arvalid_i,
  output logic [`BUS_DATA_W-1:0]   lsu_rdata_o,
  output logic                     lsu_rvalid_o,

  input  logic [`BUS_ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]   lsu_wdata_i,
  input  logic [7:0]               lsu_wstrb_i,
  input  logic                     lsu_wvalid_i,
  output logic                     lsu_wready_o,

  output logic [`BUS_ADDR_W-1:0]   m_araddr_o,
  output axi_size_t                m_arsize_o,
  output logic                     m_arvalid_o,
  input  logic                     m_arready_i,
  input  logic [2*`BUS_DATA_W-1:0] m_rdata_i,
  input  axi_resp_t                m_rresp_i,
  input  logic                     m_rvalid_i,
  output logic [`BUS_ADDR_W-1:0]   m_awaddr_o,
  output axi_size_t                m_awsize_o,
  output logic                     m_awvalid_o,
  input  logic                     m_awready_i,
  output logic [2*`BUS_DATA_W-1:0] m_wdata_o,
  output logic [7:0]               m_wstrb_o,
  output logic                     m_wlast_o,
  output logic                     m_wvalid_o,
  input  logic                     m_wready_i,
  input  axi_resp_t                m_bresp_i,
  input  logic                     m_bvalid_i
);

  logic [`BUS_ADDR_W-1:0] sel_araddr;
  logic [7:0]             sel_rstrb;
  logic                   ifetch;
  logic [`BUS_DATA_W-1:0] lane_rdata;
  logic                   clint_arvalid;
  logic [`BUS_DATA_W-1:0] clint_rdata;
  logic                   clint_rvalid;

  // single beats only
  assign m_wlast_o  = m_wvalid_o;
  assign m_araddr_o = sel_araddr;
  assign m_awaddr_o = lsu_awaddr_i;

  bus_arbiter arb0 (
    .clk            (clk),
    .rst            (rst),
    .ifu_araddr_i   (ifu_araddr_i),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_rdata_o    (ifu_rdata_o),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_rdata_o    (lsu_rdata_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_wready_o   (lsu_wready_o),
    .m_arvalid_o    (m_arvalid_o),
    .m_arready_i    (m_arready_i),
    .m_rvalid_i     (m_rvalid_i),
    .m_awvalid_o    (m_awvalid_o),
    .m_awready_i    (m_awready_i),
    .m_wvalid_o     (m_wvalid_o),
    .m_wready_i     (m_wready_i),
    .m_bvalid_i     (m_bvalid_i),
    .sel_araddr_o   (sel_araddr),
    .sel_rstrb_o    (sel_rstrb),
    .ifetch_o       (ifetch),
    .lane_rdata_i   (lane_rdata),
    .clint_arvalid_o(clint_arvalid),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid)
  );

  axi_lane_align align0 (
    .sel_araddr_i(sel_araddr),
    .sel_rstrb_i (sel_rstrb),
    .ifetch_i    (ifetch),
    .lsu_awaddr_i(lsu_awaddr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .lsu_wstrb_i (lsu_wstrb_i),
    .m_rdata_i   (m_rdata_i),
    .m_arsize_o  (m_arsize_o),
    .m_awsize_o  (m_awsize_o),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .lane_rdata_o(lane_rdata)
  );

  clint_timer clint0 (
    .clk      (clk),
    .rst      (rst),
    .araddr_i (lsu_araddr_i),
    .arvalid_i(clint_arvalid),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

endmodule

//--- sim/core_bus_checker.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module core_bus_checker (
  input  logic        clk,
  input  logic        rst,
  input  int          kind_i,
  input  int          test_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [7:0]  strb_i,
  input  logic [31:0] exp_i,
  input  logic [31:0] exp2_i,
  input  logic        end_i,
  input  logic        ifu_rvalid_i,
  input  logic [31:0] ifu_rdata_i,
  input  logic        lsu_rvalid_i,
  input  logic [31:0] lsu_rdata_i,
  input  logic        lsu_wready_i,
  input  logic        m_arvalid_i,
  input  logic        m_arready_i,
  input  logic [2:0]  m_arsize_i,
  input  logic        m_awvalid_i,
  input  logic        m_awready_i,
  input  logic [2:0]  m_awsize_i,
  input  logic        m_wvalid_i,
  input  logic        m_wready_i,
  input  logic [63:0] m_wdata_i,
  input  logic [7:0]  m_wstrb_i,
  output int          pass_cnt_o,
  output int          fail_cnt_o
);

  localparam int K_IDLE  = 0;
  localparam int K_FETCH = 1;
  localparam int K_LOAD  = 2;
  localparam int K_STORE = 3;
  localparam int K_BOTH  = 4;
  localparam int K_TIME  = 5;

  int          n_if;
  int          n_ls;
  int          n_wr;
  int          n_ar;
  int          errs;
  logic        have_lo;
  logic [31:0] last_lo;
  logic [31:0] sh_data;
  logic [3:0]  sh_strb;
  logic [7:0]  exp_strb;

  initial
  begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    n_if       = 0;
    n_ls       = 0;
    n_wr       = 0;
    n_ar       = 0;
    errs       = 0;
    have_lo    = 1'b0;
  end

  // axi size is log2 of the bytes in the beat
  function automatic logic [2:0] beat_size(input logic [7:0] strb);
    case ($countones(strb))
      1:       return 3'd0;
      2:       return 3'd1;
      default: return 3'd2;
    endcase
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: test %0d %s is %h, expected %h", $time, test_i, what, got, exp);
      errs++;
    end
  endtask

  task automatic complain(input string what);
    $display("test %0d: %s", test_i, what);
    errs++;
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (kind_i == K_IDLE && (ifu_rvalid_i || lsu_rvalid_i || lsu_wready_i
                               || m_arvalid_i || m_awvalid_i || m_wvalid_i))
        complain("a valid output went high with no request");
      if (ifu_rvalid_i)
      begin
        n_if++;
        if (kind_i == K_BOTH && n_ls == 0)
          complain("the fetch finished before the load");
        compare("fetch data", ifu_rdata_i, (kind_i == K_BOTH) ? exp2_i : exp_i);
      end
      if (lsu_rvalid_i)
      begin
        n_ls++;
        if (kind_i == K_TIME && addr_i == `BUS_RTC_ADDR)
        begin
          if (have_lo && lsu_rdata_i <= last_lo)
            complain("the timer low half did not increase");
          last_lo = lsu_rdata_i;
          have_lo = 1'b1;
        end
        else
          compare("load data", lsu_rdata_i, exp_i);
      end
      if (lsu_wready_i)
        n_wr++;
      if (m_arvalid_i && m_arready_i)
      begin
        n_ar++;
        // fetches are always full words
        compare("read size", m_arsize_i, (kind_i == K_FETCH) ? 3'd2 : beat_size(strb_i));
      end
      if (m_awvalid_i && m_awready_i)
        compare("write size", m_awsize_i, beat_size(strb_i));
      // write beat from the lane rules
      if (m_wvalid_i && m_wready_i)
      begin
        sh_data  = wdata_i << (8 * addr_i[1:0]);
        sh_strb  = strb_i[3:0] << addr_i[1:0];
        exp_strb = addr_i[2] ? {sh_strb, 4'b0000} : {4'b0000, sh_strb};
        compare("write data", m_wdata_i, {sh_data, sh_data});
        compare("write strobe", m_wstrb_i, exp_strb);
      end
      if (end_i)
      begin
        if (n_if != ((kind_i == K_FETCH || kind_i == K_BOTH) ? 1 : 0))
          complain("wrong number of fetch responses");
        if (n_ls != ((kind_i == K_LOAD || kind_i == K_BOTH || kind_i == K_TIME) ? 1 : 0))
          complain("wrong number of load responses");
        if (n_wr != ((kind_i == K_STORE) ? 1 : 0))
          complain("wrong number of store completions");
        if (kind_i == K_TIME && n_ar != 0)
          complain("a timer read went out on the axi ar channel");
        if (errs == 0)
        begin
          $display("test %0d ok", test_i);
          pass_cnt_o++;
        end
        else
        begin
          $display("test %0d failed with %0d errors", test_i, errs);
          fail_cnt_o++;
        end
        n_if = 0;
        n_ls = 0;
        n_wr = 0;
        n_ar = 0;
        errs = 0;
      end
    end
  end

endmodule

//--- sim/core_bus_assert.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module core_bus_assert (
  input logic        clk,
  input logic        rst,
  input logic        m_arvalid_i,
  input logic        m_arready_i,
  input logic [31:0] m_araddr_i,
  input logic        m_awvalid_i,
  input logic        m_awready_i,
  input logic [31:0] m_awaddr_i,
  input logic        m_wvalid_i,
  input logic        m_wready_i,
  input logic [63:0] m_wdata_i,
  input logic        m_wlast_i,
  input logic        clint_arvalid_i,
  input logic        lsu_rvalid_i
);

  // assertion failures seen so far
  int n_fail = 0;

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_i && !m_arready_i |=> m_arvalid_i && $stable(m_araddr_i))
  else
  begin
    $error("ar valid or address changed before ready");
    n_fail++;
  end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    m_awvalid_i && !m_awready_i |=> m_awvalid_i && $stable(m_awaddr_i))
  else
  begin
    $error("aw valid or address changed before ready");
    n_fail++;
  end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    m_wvalid_i && !m_wready_i |=> m_wvalid_i && $stable(m_wdata_i))
  else
  begin
    $error("w valid or data changed before ready");
    n_fail++;
  end

  w_last: assert property (@(posedge clk) disable iff (rst) m_wvalid_i |-> m_wlast_i)
  else
  begin
    $error("wvalid without wlast");
    n_fail++;
  end

  // timer addresses stay off the bus
  no_timer_ar: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_i |-> (m_araddr_i != `BUS_RTC_ADDR) && (m_araddr_i != `BUS_RTC_ADDR_UP))
  else
  begin
    $error("ar issued for a timer address");
    n_fail++;
  end

  timer_lat: assert property (@(posedge clk) disable iff (rst) clint_arvalid_i |=> lsu_rvalid_i)
  else
  begin
    $error("timer read response not one cycle after request");
    n_fail++;
  end

endmodule

bind core_bus_top core_bus_assert asrt0 (
  .clk            (clk),
  .rst            (rst),
  .m_arvalid_i    (m_arvalid_o),
  .m_arready_i    (m_arready_i),
  .m_araddr_i     (m_araddr_o),
  .m_awvalid_i    (m_awvalid_o),
  .m_awready_i    (m_awready_i),
  .m_awaddr_i     (m_awaddr_o),
  .m_wvalid_i     (m_wvalid_o),
  .m_wready_i     (m_wready_i),
  .m_wdata_i      (m_wdata_o),
  .m_wlast_i      (m_wlast_o),
  .clint_arvalid_i(clint_arvalid),
  .lsu_rvalid_i   (lsu_rvalid_o)
);

//--- sim/core_bus_tb.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module core_bus_tb
  import axi_pkg::*;
;

  localparam int TESTS   = 21;
  localparam int K_IDLE  = 0;
  localparam int K_FETCH = 1;
  localparam int K_LOAD  = 2;
  localparam int K_STORE = 3;
  localparam int K_BOTH  = 4;
  localparam int K_TIME  = 5;

  logic clk;
  logic rst;
  logic [31:0] ifu_araddr;
  logic ifu_arvalid;
  logic [31:0] ifu_rdata;
  logic ifu_rvalid;
  logic [31:0] lsu_araddr;
  logic [7:0] lsu_rstrb;
  logic lsu_arvalid;
  logic [31:0] lsu_rdata;
  logic lsu_rvalid;
  logic [31:0] lsu_awaddr;
  logic [31:0] lsu_wdata;
  logic [7:0] lsu_wstrb;
  logic lsu_wvalid;
  logic lsu_wready;
  logic [31:0] m_araddr;
  axi_size_t m_arsize;
  logic m_arvalid;
  logic m_arready;
  logic [63:0] m_rdata;
  axi_resp_t m_rresp;
  logic m_rvalid;
  logic [31:0] m_awaddr;
  axi_size_t m_awsize;
  logic m_awvalid;
  logic m_awready;
  logic [63:0] m_wdata;
  logic [7:0] m_wstrb;
  logic m_wlast;
  logic m_wvalid;
  logic m_wready;
  axi_resp_t m_bresp;
  logic m_bvalid;

  // stimulus table
  int          t_kind  [0:TESTS-1];
  logic [31:0] t_addr  [0:TESTS-1];
  logic [31:0] t_addr2 [0:TESTS-1];
  logic [31:0] t_wdata [0:TESTS-1];
  logic [7:0]  t_strb  [0:TESTS-1];
  logic [31:0] t_exp   [0:TESTS-1];
  logic [31:0] t_exp2  [0:TESTS-1];

  // checker inputs
  int          kind_r;
  int          test_r;
  logic [31:0] addr_r;
  logic [31:0] wdata_r;
  logic [7:0]  strb_r;
  logic [31:0] exp_r;
  logic [31:0] exp2_r;
  logic        end_r;
  int          pass_cnt;
  int          fail_cnt;
  logic        timed_out;

  // slave memory state
  logic [63:0] mem [0:255];
  integer      seed;
  logic        r_pend;
  logic [1:0]  r_cnt;
  logic [31:0] r_addr;
  logic        aw_got;
  logic        w_got;
  logic [31:0] aw_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;
  logic        b_pend;
  logic [1:0]  b_cnt;

  core_bus_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .ifu_araddr_i (ifu_araddr),
    .ifu_arvalid_i(ifu_arvalid),
    .ifu_rdata_o  (ifu_rdata),
    .ifu_rvalid_o (ifu_rvalid),
    .lsu_araddr_i (lsu_araddr),
    .lsu_rstrb_i  (lsu_rstrb),
    .lsu_arvalid_i(lsu_arvalid),
    .lsu_rdata_o  (lsu_rdata),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_awaddr_i (lsu_awaddr),
    .lsu_wdata_i  (lsu_wdata),
    .lsu_wstrb_i  (lsu_wstrb),
    .lsu_wvalid_i (lsu_wvalid),
    .lsu_wready_o (lsu_wready),
    .m_araddr_o   (m_araddr),
    .m_arsize_o   (m_arsize),
    .m_arvalid_o  (m_arvalid),
    .m_arready_i  (m_arready),
    .m_rdata_i    (m_rdata),
    .m_rresp_i    (m_rresp),
    .m_rvalid_i   (m_rvalid),
    .m_awaddr_o   (m_awaddr),
    .m_awsize_o   (m_awsize),
    .m_awvalid_o  (m_awvalid),
    .m_awready_i  (m_awready),
    .m_wdata_o    (m_wdata),
    .m_wstrb_o    (m_wstrb),
    .m_wlast_o    (m_wlast),
    .m_wvalid_o   (m_wvalid),
    .m_wready_i   (m_wready),
    .m_bresp_i    (m_bresp),
    .m_bvalid_i   (m_bvalid)
  );

  core_bus_checker chk0 (
    .clk         (clk),
    .rst         (rst),
    .kind_i      (kind_r),
    .test_i      (test_r),
    .addr_i      (addr_r),
    .wdata_i     (wdata_r),
    .strb_i      (strb_r),
    .exp_i       (exp_r),
    .exp2_i      (exp2_r),
    .end_i       (end_r),
    .ifu_rvalid_i(ifu_rvalid),
    .ifu_rdata_i (ifu_rdata),
    .lsu_rvalid_i(lsu_rvalid),
    .lsu_rdata_i (lsu_rdata),
    .lsu_wready_i(lsu_wready),
    .m_arvalid_i (m_arvalid),
    .m_arready_i (m_arready),
    .m_arsize_i  (m_arsize),
    .m_awvalid_i (m_awvalid),
    .m_awready_i (m_awready),
    .m_awsize_i  (m_awsize),
    .m_wvalid_i  (m_wvalid),
    .m_wready_i  (m_wready),
    .m_wdata_i   (m_wdata),
    .m_wstrb_i   (m_wstrb),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt)
  );

  always #50 clk = ~clk;

  // memory fill, every word tagged with its own byte address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [63:0] merge_beat(input logic [63:0] old_v, input logic [63:0] new_v,
                                             input logic [7:0] strb);
    axi_beat_u o;
    axi_beat_u n;
    o = old_v;
    n = new_v;
    for (int b = 0; b < 8; b++)
    begin
      if (strb[b])
        o.bytes[b] = n.bytes[b];
    end
    return o;
  endfunction

  // read channel with random ready and latency
  always @(posedge clk)
  begin
    if (rst)
    begin
      m_arready <= 1'b0;
      m_rvalid  <= 1'b0;
      r_pend    <= 1'b0;
    end
    else
    begin
      m_rvalid  <= 1'b0;
      m_arready <= $random(seed) & 1;
      if (r_pend)
      begin
        if (r_cnt == 2'd0)
        begin
          m_rvalid <= 1'b1;
          m_rdata  <= mem[r_addr[10:3]];
          r_pend   <= 1'b0;
        end
        else
          r_cnt <= r_cnt - 2'd1;
      end
      if (m_arvalid && m_arready)
      begin
        r_pend <= 1'b1;
        r_addr <= m_araddr;
        r_cnt  <= $random(seed) & 3;
      end
    end
  end

  // write channels, aw and w accepted in any order
  always @(posedge clk)
  begin
    if (rst)
    begin
      m_awready <= 1'b0;
      m_wready  <= 1'b0;
      m_bvalid  <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
    end
    else
    begin
      m_bvalid  <= 1'b0;
      m_awready <= $random(seed) & 1;
      m_wready  <= $random(seed) & 1;
      if (m_awvalid && m_awready)
      begin
        aw_got  <= 1'b1;
        aw_addr <= m_awaddr;
      end
      if (m_wvalid && m_wready)
      begin
        w_got  <= 1'b1;
        w_data <= m_wdata;
        w_strb <= m_wstrb;
      end
      if (aw_got && w_got && !b_pend && !m_bvalid)
      begin
        mem[aw_addr[10:3]] <= merge_beat(mem[aw_addr[10:3]], w_data, w_strb);
        b_pend <= 1'b1;
        b_cnt  <= $random(seed) & 3;
      end
      if (b_pend)
      begin
        if (b_cnt == 2'd0)
        begin
          m_bvalid <= 1'b1;
          b_pend   <= 1'b0;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
        end
        else
          b_cnt <= b_cnt - 2'd1;
      end
    end
  end

  task automatic set_row(input int i, input int kind, input logic [31:0] addr,
                         input logic [31:0] addr2, input logic [31:0] wdata,
                         input logic [7:0] strb, input logic [31:0] exp,
                         input logic [31:0] exp2);
    t_kind[i]  = kind;
    t_addr[i]  = addr;
    t_addr2[i] = addr2;
    t_wdata[i] = wdata;
    t_strb[i]  = strb;
    t_exp[i]   = exp;
    t_exp2[i]  = exp2;
  endtask

  task automatic load_table();
    set_row(0,  K_IDLE,  32'h0,   32'h0,   32'h0,         8'h00, 32'h0,         32'h0);
    set_row(1,  K_FETCH, 32'h100, 32'h0,   32'h0,         8'h0f, 32'h5a5a_0100, 32'h0);
    set_row(2,  K_FETCH, 32'h104, 32'h0,   32'h0,         8'h0f, 32'h5a5a_0104, 32'h0);
    set_row(3,  K_LOAD,  32'h10c, 32'h0,   32'h0,         8'h0f, 32'h5a5a_010c, 32'h0);
    set_row(4,  K_STORE, 32'h201, 32'h0,   32'h0000_00ab, 8'h01, 32'h0,         32'h0);
    set_row(5,  K_STORE, 32'h202, 32'h0,   32'h0000_1234, 8'h03, 32'h0,         32'h0);
    set_row(6,  K_LOAD,  32'h200, 32'h0,   32'h0,         8'h0f, 32'h1234_ab00, 32'h0);
    set_row(7,  K_STORE, 32'h204, 32'h0,   32'h0000_00cd, 8'h01, 32'h0,         32'h0);
    set_row(8,  K_STORE, 32'h207, 32'h0,   32'h0000_00ef, 8'h01, 32'h0,         32'h0);
    set_row(9,  K_LOAD,  32'h204, 32'h0,   32'h0,         8'h0f, 32'hef5a_02cd, 32'h0);
    set_row(10, K_STORE, 32'h208, 32'h0,   32'h0000_beef, 8'h03, 32'h0,         32'h0);
    set_row(11, K_STORE, 32'h20c, 32'h0,   32'h1122_3344, 8'h0f, 32'h0,         32'h0);
    set_row(12, K_LOAD,  32'h208, 32'h0,   32'h0,         8'h0f, 32'h5a5a_beef, 32'h0);
    set_row(13, K_LOAD,  32'h20c, 32'h0,   32'h0,         8'h0f, 32'h1122_3344, 32'h0);
    set_row(14, K_STORE, 32'h20a, 32'h0,   32'h0000_0077, 8'h01, 32'h0,         32'h0);
    set_row(15, K_LOAD,  32'h208, 32'h0,   32'h0,         8'h0f, 32'h5a77_beef, 32'h0);
    set_row(16, K_BOTH,  32'h300, 32'h144, 32'h0,         8'h0f, 32'h5a5a_0300, 32'h5a5a_0144);
    set_row(17, K_BOTH,  32'h20c, 32'h100, 32'h0,         8'h0f, 32'h1122_3344, 32'h5a5a_0100);
    set_row(18, K_TIME,  `BUS_RTC_ADDR,    32'h0, 32'h0,  8'h0f, 32'h0,         32'h0);
    set_row(19, K_TIME,  `BUS_RTC_ADDR_UP, 32'h0, 32'h0,  8'h0f, 32'h0,         32'h0);
    set_row(20, K_TIME,  `BUS_RTC_ADDR,    32'h0, 32'h0,  8'h0f, 32'h0,         32'h0);
  endtask

  task automatic run_row(input int i);
    int   wait_cnt;
    logic need_if;
    logic need_ls;
    logic need_wr;
    need_if  = (t_kind[i] == K_FETCH) || (t_kind[i] == K_BOTH);
    need_ls  = (t_kind[i] == K_LOAD) || (t_kind[i] == K_BOTH) || (t_kind[i] == K_TIME);
    need_wr  = (t_kind[i] == K_STORE);
    wait_cnt = 0;
    @(posedge clk);
    kind_r  <= t_kind[i];
    test_r  <= i;
    addr_r  <= t_addr[i];
    wdata_r <= t_wdata[i];
    strb_r  <= t_strb[i];
    exp_r   <= t_exp[i];
    exp2_r  <= t_exp2[i];
    if (t_kind[i] == K_FETCH)
    begin
      ifu_araddr  <= t_addr[i];
      ifu_arvalid <= 1'b1;
    end
    if (t_kind[i] == K_BOTH)
    begin
      ifu_araddr  <= t_addr2[i];
      ifu_arvalid <= 1'b1;
    end
    if (need_ls)
    begin
      lsu_araddr  <= t_addr[i];
      lsu_rstrb   <= t_strb[i];
      lsu_arvalid <= 1'b1;
    end
    if (need_wr)
    begin
      lsu_awaddr <= t_addr[i];
      lsu_wdata  <= t_wdata[i];
      lsu_wstrb  <= t_strb[i];
      lsu_wvalid <= 1'b1;
    end
    if (t_kind[i] == K_IDLE)
      repeat (5) @(posedge clk);
    while ((need_if || need_ls || need_wr) && !timed_out)
    begin
      @(posedge clk);
      if (need_if && ifu_rvalid)
      begin
        ifu_arvalid <= 1'b0;
        need_if = 1'b0;
      end
      if (need_ls && lsu_rvalid)
      begin
        lsu_arvalid <= 1'b0;
        need_ls = 1'b0;
      end
      if (need_wr && lsu_wready)
      begin
        lsu_wvalid <= 1'b0;
        need_wr = 1'b0;
      end
      wait_cnt++;
      if (wait_cnt > 200)
      begin
        $display("timeout: test %0d got no response from the bus", i);
        timed_out = 1'b1;
      end
    end
    end_r <= 1'b1;
    @(posedge clk);
    end_r <= 1'b0;
    @(posedge clk);
  endtask

  initial
  begin
    seed        = 44;
    timed_out   = 1'b0;
    clk         = 1'b0;
    rst         = 1'b1;
    ifu_araddr  = 32'h0;
    ifu_arvalid = 1'b0;
    lsu_araddr  = 32'h0;
    lsu_rstrb   = 8'h0;
    lsu_arvalid = 1'b0;
    lsu_awaddr  = 32'h0;
    lsu_wdata   = 32'h0;
    lsu_wstrb   = 8'h0;
    lsu_wvalid  = 1'b0;
    m_arready   = 1'b0;
    m_rdata     = 64'h0;
    m_rresp     = AXI_RESP_OKAY;
    m_rvalid    = 1'b0;
    m_awready   = 1'b0;
    m_wready    = 1'b0;
    m_bresp     = AXI_RESP_OKAY;
    m_bvalid    = 1'b0;
    kind_r      = K_IDLE;
    test_r      = 0;
    addr_r      = 32'h0;
    wdata_r     = 32'h0;
    strb_r      = 8'h0;
    exp_r       = 32'h0;
    exp2_r      = 32'h0;
    end_r       = 1'b0;
    for (int i = 0; i < 256; i++)
      mem[i] = {fill_word(i * 8 + 4), fill_word(i * 8)};
    load_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < TESTS && !timed_out; i++)
      run_row(i);
    repeat (2) @(posedge clk);
    $display("tests passed %0d failed %0d of %0d", pass_cnt, fail_cnt, TESTS);
    if (!timed_out && fail_cnt == 0 && pass_cnt == TESTS && dut0.asrt0.n_fail == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+design
design/axi_pkg.sv
design/core_bus_pkg.sv
design/bus_arbiter.sv
design/axi_lane_align.sv
design/clint_timer.sv
design/core_bus_top.sv
sim/core_bus_checker.sv
sim/core_bus_assert.sv
sim/core_bus_tb.sv
